// File: list.f
verilog/cfu_cmd_pkg.sv
verilog/tpu_pkg.sv
verilog/operand_buffer.sv
verilog/mac_pe.sv
verilog/data_skew.sv
verilog/systolic_array.sv
verilog/tpu_core.sv
verilog/cfu_controller.sv
verilog/cfu_top.sv
dv/cfu_assertions.sv
dv/cfu_tb.sv

// File: dv/cfu_tb.sv
// testbench for cfu_top: clock, reset, command tasks, reference model, checks, watchdog
`timescale 1ns/10ps
`default_nettype none

module cfu_tb;

  logic                 clk;
  logic                 rst_n;
  logic                 cmd_valid;
  cfu_cmd_pkg::cmd_t    cmd;
  logic                 cmd_ready;
  logic                 rsp_valid;
  logic                 rsp_ready;
  cfu_cmd_pkg::data_t   rsp_data;

  // host side copies of the buffers and the expected tile
  logic [31:0]          a_mem [256];
  logic [31:0]          b_mem [256];
  cfu_cmd_pkg::data_t   ref_c [4][4];
  cfu_cmd_pkg::data_t   exp_q [$];
  cfu_cmd_pkg::data_t   got_q [$];
  string                tag_q [$];
  event                 rsp_taken;
  int                   cmd_count;
  int                   stall_max;

  cfu_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_failure(string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // C[r][c] from the stated layout, byte [31:24] is lane 0
  function automatic cfu_cmd_pkg::data_t ref_result(int k_len, int r, int c);
    logic signed [7:0]  ea;
    logic signed [7:0]  eb;
    logic signed [31:0] sum;
    sum = '0;
    for (int k = 0; k < k_len; k++) begin
      ea  = a_mem[k][31-8*r -: 8];
      eb  = b_mem[k][31-8*c -: 8];
      sum = sum + ea * eb;
    end
    return sum;
  endfunction

  // starts and ends just after a falling edge
  task automatic send_cmd(cfu_cmd_pkg::opcode_t op, int in0, int in1);
    cmd_valid           = 1'b1;
    cmd.function_id     = {op, 3'b000};
    cmd.in0             = in0;
    cmd.in1             = in1;
    cmd_count++;
    while (!cmd_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic get_rsp();
    int                 stall;
    cfu_cmd_pkg::data_t held;
    stall     = (stall_max == 0) ? 0 : $urandom_range(stall_max, 0);
    rsp_ready = 1'b0;
    while (!rsp_valid) begin
      @(negedge clk);
    end
    held = rsp_data;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      assert (rsp_valid) else report_failure("response withdrawn while rsp_ready was low");
      assert (rsp_data == held)
        else report_failure($sformatf("FAILED rsp_data changed: got %h expected %h",
                                      rsp_data, held));
      assert (!cmd_ready)
        else report_failure($sformatf("FAILED cmd_ready: got %h expected %h", cmd_ready, 1'b0));
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    got_q.push_back(held);
    -> rsp_taken;
  endtask

  task automatic transact(cfu_cmd_pkg::opcode_t op, int in0, int in1,
                          cfu_cmd_pkg::data_t exp, string tag);
    exp_q.push_back(exp);
    tag_q.push_back(tag);
    send_cmd(op, in0, in1);
    get_rsp();
  endtask

  task automatic fill_random(int n);
    for (int i = 0; i < n; i++) begin
      a_mem[i] = $urandom;
      b_mem[i] = $urandom;
      transact(cfu_cmd_pkg::OP_WRITE_A, i, a_mem[i], '0, "write A");
      transact(cfu_cmd_pkg::OP_WRITE_B, i, b_mem[i], '0, "write B");
    end
  endtask

  task automatic run_compute(int k_len);
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        ref_c[r][c] = ref_result(k_len, r, c);
      end
    end
    transact(cfu_cmd_pkg::OP_COMPUTE, k_len, 0, '0, $sformatf("compute K=%0d", k_len));
  endtask

  task automatic read_tile();
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        transact(cfu_cmd_pkg::OP_READ_C, r, c, ref_c[r][c], $sformatf("C[%0d][%0d]", r, c));
      end
    end
  endtask

  // pairs each taken response with the value expected for it
  initial begin : compare
    cfu_cmd_pkg::data_t got;
    cfu_cmd_pkg::data_t exp;
    string              tag;
    forever begin
      @(rsp_taken);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        exp = exp_q.pop_front();
        tag = tag_q.pop_front();
        assert (got == exp)
          else report_failure($sformatf("FAILED rsp_data for %s: got %h expected %h",
                                        tag, got, exp));
      end
    end
  end

  // budget grows with every command sent
  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 300 * (cmd_count + 1)) begin
        report_failure("timeout: the DUT stopped answering commands");
      end
    end
  end

  // stops the run at the first failed handshake assertion
  initial begin : assertion_monitor
    wait (dut.u_assert.fail_count != 0);
    report_failure("a handshake assertion failed during the run");
  end

  initial begin
    void'($urandom(63200));
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    rsp_ready = 1'b0;
    cmd_count = 0;
    stall_max = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // small tile, then random K over the full depth
    fill_random(4);
    run_compute(4);
    read_tile();
    fill_random(256);
    repeat (2) begin
      run_compute($urandom_range(256, 1));
      read_tile();
    end

    // most negative operands at full depth
    for (int i = 0; i < 256; i++) begin
      a_mem[i] = 32'h8080_8080;
      b_mem[i] = 32'h8080_8080;
      transact(cfu_cmd_pkg::OP_WRITE_A, i, a_mem[i], '0, "write A");
      transact(cfu_cmd_pkg::OP_WRITE_B, i, b_mem[i], '0, "write B");
    end
    transact(cfu_cmd_pkg::OP_COMPUTE, 256, 0, '0, "compute K=256");
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        transact(cfu_cmd_pkg::OP_READ_C, r, c, 32'h0040_0000, $sformatf("C[%0d][%0d]", r, c));
      end
    end

    // back-pressure from here on
    stall_max = 6;
    fill_random(8);
    run_compute(8);
    read_tile();

    // back to back computes, then an empty one
    fill_random(16);
    run_compute(16);
    read_tile();
    fill_random(16);
    run_compute(16);
    read_tile();
    run_compute(0);
    read_tile();

    // unknown opcode leaves C alone
    run_compute(3);
    read_tile();
    transact(7'h55, 0, 0, '0, "unknown opcode");
    read_tile();

    @(negedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/cfu_assertions.sv
// response handshake and reset assertions, bound into cfu_top
`timescale 1ns/10ps
`default_nettype none

module cfu_assertions (
  input wire                     clk,
  input wire                     rst_n,
  input wire                     cmd_ready,
  input wire                     rsp_valid,
  input wire                     rsp_ready,
  input wire cfu_cmd_pkg::data_t rsp_data
);

  int unsigned fail_count = 0;

  // a pending response keeps its data until the host takes it
  assert property (@(posedge clk) disable iff (!rst_n)
                   rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
      fail_count++;
      $error("response dropped or changed before rsp_ready");
    end

  // one command in flight
  assert property (@(posedge clk) disable iff (!rst_n) !(cmd_ready && rsp_valid))
    else begin
      fail_count++;
      $error("cmd_ready and rsp_valid high in the same cycle");
    end

  // controller sits idle with no response while reset is held
  assert property (@(posedge clk) !rst_n |-> !rsp_valid && cmd_ready)
    else begin
      fail_count++;
      $error("response or busy controller during reset");
    end

endmodule

bind cfu_top cfu_assertions u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .cmd_ready (cmd_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp_data  (rsp_data)
);

`default_nettype wire

// File: verilog/cfu_top.sv
// top level of the matrix unit: controller, A/B/C buffers and compute core
`timescale 1ns/10ps
`default_nettype none

module cfu_top (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                cmd_valid,
  input  wire                cfu_cmd_pkg::cmd_t cmd,
  output logic               cmd_ready,
  output logic               rsp_valid,
  input  wire                rsp_ready,
  output cfu_cmd_pkg::data_t rsp_data
);

  logic              a_wr_en;
  tpu_pkg::ab_addr_t a_addr;
  tpu_pkg::word_t    a_wdata;
  tpu_pkg::word_t    a_rdata;
  logic              b_wr_en;
  tpu_pkg::ab_addr_t b_addr;
  tpu_pkg::word_t    b_wdata;
  tpu_pkg::word_t    b_rdata;
  logic              c_wr_en;
  tpu_pkg::c_addr_t  c_addr;
  tpu_pkg::row_t     c_wdata;
  tpu_pkg::row_t     c_rdata;
  logic              tpu_start;
  tpu_pkg::k_len_t   tpu_k_len;
  logic              tpu_done;
  tpu_pkg::ab_addr_t tpu_k_addr;
  logic              tpu_c_wr_en;
  tpu_pkg::c_addr_t  tpu_c_addr;
  tpu_pkg::row_t     tpu_c_row;

  cfu_controller u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_ready   (cmd_ready),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_data    (rsp_data),
    .tpu_start   (tpu_start),
    .tpu_k_len   (tpu_k_len),
    .tpu_done    (tpu_done),
    .tpu_k_addr  (tpu_k_addr),
    .tpu_c_wr_en (tpu_c_wr_en),
    .tpu_c_addr  (tpu_c_addr),
    .tpu_c_row   (tpu_c_row),
    .a_wr_en     (a_wr_en),
    .a_addr      (a_addr),
    .a_wdata     (a_wdata),
    .b_wr_en     (b_wr_en),
    .b_addr      (b_addr),
    .b_wdata     (b_wdata),
    .c_wr_en     (c_wr_en),
    .c_addr      (c_addr),
    .c_wdata     (c_wdata),
    .c_rdata     (c_rdata)
  );

  operand_buffer #(
    .ADDR_W (tpu_pkg::AB_ADDR_W),
    .DATA_W ($bits(tpu_pkg::word_t))
  ) buf_a (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (a_wr_en),
    .addr  (a_addr),
    .wdata (a_wdata),
    .rdata (a_rdata)
  );

  operand_buffer #(
    .ADDR_W (tpu_pkg::AB_ADDR_W),
    .DATA_W ($bits(tpu_pkg::word_t))
  ) buf_b (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (b_wr_en),
    .addr  (b_addr),
    .wdata (b_wdata),
    .rdata (b_rdata)
  );

  operand_buffer #(
    .ADDR_W (tpu_pkg::C_ADDR_W),
    .DATA_W ($bits(tpu_pkg::row_t))
  ) buf_c (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (c_wr_en),
    .addr  (c_addr),
    .wdata (c_wdata),
    .rdata (c_rdata)
  );

  tpu_core u_core (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (tpu_start),
    .k_len   (tpu_k_len),
    .done    (tpu_done),
    .k_addr  (tpu_k_addr),
    .a_word  (a_rdata),
    .b_word  (b_rdata),
    .c_wr_en (tpu_c_wr_en),
    .c_addr  (tpu_c_addr),
    .c_row   (tpu_c_row)
  );

endmodule

`default_nettype wire

// File: verilog/cfu_controller.sv
// command decoder FSM, buffer port muxing and response generation
`timescale 1ns/10ps
`default_nettype none

module cfu_controller (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                cmd_valid,
  input  wire                cfu_cmd_pkg::cmd_t cmd,
  output logic               cmd_ready,
  output logic               rsp_valid,
  input  wire                rsp_ready,
  output cfu_cmd_pkg::data_t rsp_data,
  output logic               tpu_start,
  output tpu_pkg::k_len_t    tpu_k_len,
  input  wire                tpu_done,
  input  wire                tpu_pkg::ab_addr_t tpu_k_addr,
  input  wire                tpu_c_wr_en,
  input  wire                tpu_pkg::c_addr_t tpu_c_addr,
  input  wire                tpu_pkg::row_t tpu_c_row,
  output logic               a_wr_en,
  output tpu_pkg::ab_addr_t  a_addr,
  output tpu_pkg::word_t     a_wdata,
  output logic               b_wr_en,
  output tpu_pkg::ab_addr_t  b_addr,
  output tpu_pkg::word_t     b_wdata,
  output logic               c_wr_en,
  output tpu_pkg::c_addr_t   c_addr,
  output tpu_pkg::row_t      c_wdata,
  input  wire                tpu_pkg::row_t c_rdata
);

  typedef enum logic [2:0] {IDLE, WRITE_A, WRITE_B, READ_C, COMPUTE, RESPOND} state_t;

  state_t                                state;
  state_t                                state_nxt;
  cfu_cmd_pkg::cmd_t                     cmd_q;
  cfu_cmd_pkg::opcode_t                  op_in;
  cfu_cmd_pkg::opcode_t                  op_q;
  logic                                  cmd_fire;
  logic                                  computing;
  logic [$clog2(tpu_pkg::ARRAY_DIM)-1:0] col_sel;

  assign op_in = cmd.function_id[cfu_cmd_pkg::FUNC_ID_W-1 -: cfu_cmd_pkg::OPCODE_W];
  assign op_q  = cmd_q.function_id[cfu_cmd_pkg::FUNC_ID_W-1 -: cfu_cmd_pkg::OPCODE_W];

  assign cmd_ready = (state == IDLE);
  assign cmd_fire  = cmd_valid && cmd_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (cmd_fire) begin
          case (op_in)
            cfu_cmd_pkg::OP_WRITE_A: state_nxt = WRITE_A;
            cfu_cmd_pkg::OP_WRITE_B: state_nxt = WRITE_B;
            cfu_cmd_pkg::OP_READ_C:  state_nxt = READ_C;
            cfu_cmd_pkg::OP_COMPUTE: state_nxt = COMPUTE;
            default:                 state_nxt = RESPOND;
          endcase
        end
      end
      // writes answer in the same cycle unless held off
      WRITE_A, WRITE_B: state_nxt = rsp_ready ? IDLE : RESPOND;
      READ_C:           state_nxt = RESPOND;
      COMPUTE:          state_nxt = tpu_done ? RESPOND : COMPUTE;
      RESPOND:          state_nxt = rsp_ready ? IDLE : RESPOND;
      default:          state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      tpu_start <= 1'b0;
    end else begin
      state     <= state_nxt;
      tpu_start <= cmd_fire && (op_in == cfu_cmd_pkg::OP_COMPUTE);
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      cmd_q <= cmd;
    end
  end

  assign tpu_k_len = tpu_pkg::k_len_t'(cmd_q.in0);
  assign computing = (state == COMPUTE);

  // core owns the buffer addresses while a tile is in progress
  assign a_wr_en = (state == WRITE_A);
  assign a_addr  = computing ? tpu_k_addr : tpu_pkg::ab_addr_t'(cmd_q.in0);
  assign a_wdata = cmd_q.in1;
  assign b_wr_en = (state == WRITE_B);
  assign b_addr  = computing ? tpu_k_addr : tpu_pkg::ab_addr_t'(cmd_q.in0);
  assign b_wdata = cmd_q.in1;
  assign c_wr_en = computing && tpu_c_wr_en;
  assign c_addr  = computing ? tpu_c_addr : tpu_pkg::c_addr_t'(cmd_q.in0);
  assign c_wdata = tpu_c_row;

  assign rsp_valid = (state == WRITE_A) || (state == WRITE_B) || (state == RESPOND);
  assign col_sel   = cmd_q.in1[$bits(col_sel)-1:0];

  // only a read returns data, everything else answers zero
  always_comb begin
    rsp_data = '0;
    if ((state == RESPOND) && (op_q == cfu_cmd_pkg::OP_READ_C)) begin
      rsp_data = c_rdata[col_sel];
    end
  end

endmodule

`default_nettype wire

// File: verilog/tpu_core.sv
// compute sequencer: operand feed, skew, array drain, tile capture and row writeback
`timescale 1ns/10ps
`default_nettype none

module tpu_core (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               start,
  input  wire               tpu_pkg::k_len_t k_len,
  output logic              done,
  output tpu_pkg::ab_addr_t k_addr,
  input  wire               tpu_pkg::word_t a_word,
  input  wire               tpu_pkg::word_t b_word,
  output logic              c_wr_en,
  output tpu_pkg::c_addr_t  c_addr,
  output tpu_pkg::row_t     c_row
);

  typedef enum logic [1:0] {IDLE, FEED, DRAIN, WRITEBACK} state_t;

  state_t          state;
  tpu_pkg::k_len_t k_len_q;
  tpu_pkg::k_len_t cnt;
  logic            feed_q;
  logic            feed_last;
  logic            drain_last;
  logic            wb_last;
  tpu_pkg::word_t  a_gated;
  tpu_pkg::word_t  b_gated;
  tpu_pkg::word_t  a_skewed;
  tpu_pkg::word_t  b_skewed;
  tpu_pkg::tile_t  tile;
  tpu_pkg::tile_t  tile_q;

  assign feed_last  = (state == FEED) && (cnt == k_len_q - 1'b1);
  assign drain_last = (state == DRAIN) &&
                      (cnt == tpu_pkg::k_len_t'(tpu_pkg::DRAIN_CYCLES - 1));
  assign wb_last    = (state == WRITEBACK) &&
                      (cnt == tpu_pkg::k_len_t'(tpu_pkg::ARRAY_DIM - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      k_len_q <= '0;
      cnt     <= '0;
      feed_q  <= 1'b0;
      done    <= 1'b0;
    end else begin
      // feed window lines up with the registered buffer read
      feed_q <= (state == FEED);
      done   <= wb_last;
      cnt    <= cnt + 1'b1;
      case (state)
        IDLE: begin
          cnt <= '0;
          if (start) begin
            k_len_q <= k_len;
            // K of zero skips the feed and drains an empty array
            if (k_len == '0) begin
              state <= DRAIN;
            end else begin
              state <= FEED;
            end
          end
        end
        FEED: begin
          if (feed_last) begin
            cnt   <= '0;
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (drain_last) begin
            cnt   <= '0;
            state <= WRITEBACK;
          end
        end
        WRITEBACK: begin
          if (wb_last) begin
            cnt   <= '0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // snapshot so the array is free while rows go out
  always_ff @(posedge clk) begin
    if (drain_last) begin
      tile_q <= tile;
    end
  end

  assign a_gated = feed_q ? a_word : '0;
  assign b_gated = feed_q ? b_word : '0;

  data_skew skew_a (
    .clk       (clk),
    .rst_n     (rst_n),
    .lanes_in  (a_gated),
    .lanes_out (a_skewed)
  );

  data_skew skew_b (
    .clk       (clk),
    .rst_n     (rst_n),
    .lanes_in  (b_gated),
    .lanes_out (b_skewed)
  );

  systolic_array u_array (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (start),
    .west    (a_skewed),
    .north   (b_skewed),
    .results (tile)
  );

  assign k_addr  = tpu_pkg::ab_addr_t'(cnt);
  assign c_wr_en = (state == WRITEBACK);
  assign c_addr  = tpu_pkg::c_addr_t'(cnt);
  assign c_row   = tile_q[c_addr];

endmodule

`default_nettype wire

// File: verilog/systolic_array.sv
// square grid of mac cells, A rows flow east and B columns flow south
`timescale 1ns/10ps
`default_nettype none

module systolic_array (
  input  wire clk,
  input  wire rst_n,
  input  wire clear,
  input  wire tpu_pkg::word_t west,
  input  wire tpu_pkg::word_t north,
  output wire tpu_pkg::tile_t results
);

  // a_link[r][c] is the A operand entering cell (r,c) from the west
  tpu_pkg::elem_t a_link [tpu_pkg::ARRAY_DIM][tpu_pkg::ARRAY_DIM+1];
  // b_link[r][c] is the B operand entering cell (r,c) from the north
  tpu_pkg::elem_t b_link [tpu_pkg::ARRAY_DIM+1][tpu_pkg::ARRAY_DIM];

  for (genvar r = 0; r < tpu_pkg::ARRAY_DIM; r++) begin : g_edge_w
    assign a_link[r][0] = west[r];
  end

  for (genvar c = 0; c < tpu_pkg::ARRAY_DIM; c++) begin : g_edge_n
    assign b_link[0][c] = north[c];
  end

  for (genvar r = 0; r < tpu_pkg::ARRAY_DIM; r++) begin : g_row
    for (genvar c = 0; c < tpu_pkg::ARRAY_DIM; c++) begin : g_col
      mac_pe u_pe (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (clear),
        .a_in  (a_link[r][c]),
        .b_in  (b_link[r][c]),
        .a_out (a_link[r][c+1]),
        .b_out (b_link[r+1][c]),
        .acc   (results[r][c])
      );
    end
  end

endmodule

`default_nettype wire

// File: verilog/data_skew.sv
// triangular delay lines, lane i of the word is delayed by i cycles
`timescale 1ns/10ps
`default_nettype none

module data_skew (
  input  wire clk,
  input  wire rst_n,
  input  wire tpu_pkg::word_t lanes_in,
  output wire tpu_pkg::word_t lanes_out
);

  for (genvar i = 0; i < tpu_pkg::ARRAY_DIM; i++) begin : g_lane
    if (i == 0) begin : g_direct
      // lane 0 enters the array without delay
      assign lanes_out[i] = lanes_in[i];
    end else begin : g_delay
      tpu_pkg::elem_t line_q [i];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int s = 0; s < i; s++) begin
            line_q[s] <= '0;
          end
        end else begin
          line_q[0] <= lanes_in[i];
          for (int s = 1; s < i; s++) begin
            line_q[s] <= line_q[s-1];
          end
        end
      end

      assign lanes_out[i] = line_q[i-1];
    end
  end

endmodule

`default_nettype wire

// File: verilog/mac_pe.sv
// signed multiply-accumulate cell with registered east/south forwarding
`timescale 1ns/10ps
`default_nettype none

module mac_pe (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            clear,
  input  wire            tpu_pkg::elem_t a_in,
  input  wire            tpu_pkg::elem_t b_in,
  output tpu_pkg::elem_t a_out,
  output tpu_pkg::elem_t b_out,
  output tpu_pkg::acc_t  acc
);

  tpu_pkg::acc_t product;

  // operands are sign extended to the accumulator width
  assign product = a_in * b_in;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_out <= '0;
      b_out <= '0;
      acc   <= '0;
    end else begin
      a_out <= a_in;
      b_out <= b_in;
      if (clear) begin
        acc <= '0;
      end else begin
        // wraps at 32 bits
        acc <= acc + product;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/operand_buffer.sv
// single-port synchronous memory with registered read output
`timescale 1ns/10ps
`default_nettype none

module operand_buffer #(
  parameter int ADDR_W = 8,
  parameter int DATA_W = 32
) (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               wr_en,
  input  wire  [ADDR_W-1:0] addr,
  input  wire  [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= wdata;
    end
  end

  // read port holds its value on a write cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (!wr_en) begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/tpu_pkg.sv
// array geometry, operand and accumulator types, buffer address types, drain length
`default_nettype none

package tpu_pkg;

  localparam int ARRAY_DIM = 4;
  localparam int ELEM_W    = 8;
  localparam int ACC_W     = 32;
  localparam int AB_ADDR_W = 8;
  localparam int C_ADDR_W  = 2;
  localparam int K_LEN_W   = AB_ADDR_W + 1;

  // registered buffer read
  localparam int READ_LATENCY = 1;
  // read, then lane skew, then the hops and the final add in the far corner cell
  localparam int DRAIN_CYCLES = READ_LATENCY + (ARRAY_DIM - 1) + ARRAY_DIM;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // index 0 is the most significant lane
  typedef elem_t [0:ARRAY_DIM-1] word_t;
  typedef acc_t  [0:ARRAY_DIM-1] row_t;
  typedef row_t  [0:ARRAY_DIM-1] tile_t;

  typedef logic [AB_ADDR_W-1:0] ab_addr_t;
  typedef logic [C_ADDR_W-1:0]  c_addr_t;

  // 0 to 256 inclusive
  typedef logic [K_LEN_W-1:0] k_len_t;

endpackage

`default_nettype wire

// File: verilog/cfu_cmd_pkg.sv
// command port encoding: function id, opcodes, operand word and command struct
`default_nettype none

package cfu_cmd_pkg;

  localparam int FUNC_ID_W = 10;
  localparam int OPCODE_W  = 7;
  localparam int DATA_W    = 32;

  // opcode sits in the upper bits, the low 3 bits are ignored
  typedef logic [FUNC_ID_W-1:0] func_id_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [DATA_W-1:0]    data_t;

  // write A/B: in0 = word address, in1 = data
  localparam opcode_t OP_WRITE_A = 7'd0;
  localparam opcode_t OP_WRITE_B = 7'd1;
  // compute: in0 = K
  localparam opcode_t OP_COMPUTE = 7'd2;
  // read C: in0 = row, in1 = column
  localparam opcode_t OP_READ_C  = 7'd3;

  typedef struct packed {
    func_id_t function_id;
    data_t    in0;
    data_t    in1;
  } cmd_t;

endpackage

`default_nettype wire
